/* tb.f */
source/matmul_pkg.sv
source/operand_buffer.sv
source/buffer_ctrl.sv
source/dot_block.sv
source/result_acc.sv
source/matmul_top.sv
verif/tb_matmul.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_matmul
FILELIST  ?= tb.f
PASS_MSG  := Verification passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* verif/tb_matmul.sv */
/*
  Table-driven testbench for matmul_top, four jobs applied back to back
  Inputs change 1 ns after the rising edge, outputs are read at the edge
  out_ack delays of 0 to 7 cycles come from a fixed-seed LFSR
*/
`timescale 1ns/1ps

module tb_matmul;

    localparam int NUM_JOBS   = 4;
    localparam int A_LEN      = matmul_pkg::ROWS_M * matmul_pkg::INNER_DIM;
    localparam int B_LEN      = matmul_pkg::INNER_DIM * matmul_pkg::COLS_N;
    localparam int C_LEN      = matmul_pkg::ROWS_M * matmul_pkg::COLS_N;
    localparam int LOADS      = matmul_pkg::N_DEPTH + matmul_pkg::W_DEPTH;
    // About 4 cycles per load word, at most 20 per result, doubled for margin
    localparam int MAX_CYCLES = NUM_JOBS * (LOADS * 4 + C_LEN * 20) * 2;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               in_req;
    matmul_pkg::block_t in_data;
    logic               in_ack;
    logic               out_req;
    matmul_pkg::sum_t   out_data;
    logic               out_ack;
    logic               busy;

    int          errors    = 0;
    int          cycles    = 0;
    int          ack_rises = 0;
    logic        ack_q     = 1'b0;
    logic        req_q     = 1'b0;
    logic [31:0] lfsr      = 32'hc3a9_1337;

    // A row-major [r*K+k], B row-major [k*N+c], C row-major [r*N+c]
    int a_tab [NUM_JOBS][A_LEN] = '{
        '{1, 2, 3, 4, 5, 6, 7, 8, -1, -2, -3, -4},
        '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{-128, -128, -128, -128, 127, 127, 127, 127, -128, 127, -128, 127},
        '{3, -5, 10, -7, 0, 20, -20, 1, -50, 60, 2, 9}
    };
    int b_tab [NUM_JOBS][B_LEN] = '{
        '{1, 0, 0, 1, 1, 1, 2, -1},
        '{7, -3, 100, -100, -128, 127, 5, 9},
        '{-128, 127, -128, 127, -128, -128, -128, 127},
        '{4, -2, -6, 8, 11, 3, 0, -9}
    };
    // Hand-computed dot products
    int c_tab [NUM_JOBS][C_LEN] = '{
        '{12, 1, 28, 5, -12, -1},
        '{0, 0, 0, 0, 0, 0},
        '{65536, -32384, -65024, 32131, 256, 32386},
        '{152, 47, -340, 91, -538, 505}
    };

    matmul_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack),
        .busy     (busy)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Three LFSR bits give 0 to 7 cycles
    task automatic next_delay(output int delay);
        logic [2:0] bits;
        bits = '0;
        for (int i = 0; i < 3; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[1:0], lfsr[0]};
        end
        delay = int'(bits);
    endtask

    task automatic check_quiet_outputs();
        if (in_ack !== 1'b0) begin
            errors++;
            $display("FAILED in_ack exp 0 got %h", in_ack);
        end
        if (out_req !== 1'b0) begin
            errors++;
            $display("FAILED out_req exp 0 got %h", out_req);
        end
        if (busy !== 1'b0) begin
            errors++;
            $display("FAILED busy exp 0 got %h", busy);
        end
    endtask

    // One four-phase load word, entered and left 1 ns after an edge
    task automatic send_block(input matmul_pkg::block_t data);
        in_data = data;
        in_req  = 1'b1;
        @(posedge clk);
        while (in_ack !== 1'b1) @(posedge clk);
        #1 in_req = 1'b0;
        @(posedge clk);
        while (in_ack !== 1'b0) @(posedge clk);
        #1;
    endtask

    // B column by column, then A row by row, element 0 in the low bits
    task automatic load_job(input int job);
        matmul_pkg::block_t blk;
        for (int c = 0; c < matmul_pkg::COLS_N; c++) begin
            for (int b = 0; b < matmul_pkg::BLOCKS_PER_VEC; b++) begin
                for (int i = 0; i < matmul_pkg::BLOCK_SIZE; i++) begin
                    blk[i] = matmul_pkg::elem_t'(
                        b_tab[job][(b * matmul_pkg::BLOCK_SIZE + i) * matmul_pkg::COLS_N + c]);
                end
                send_block(blk);
            end
        end
        for (int r = 0; r < matmul_pkg::ROWS_M; r++) begin
            for (int b = 0; b < matmul_pkg::BLOCKS_PER_VEC; b++) begin
                for (int i = 0; i < matmul_pkg::BLOCK_SIZE; i++) begin
                    blk[i] = matmul_pkg::elem_t'(
                        a_tab[job][r * matmul_pkg::INNER_DIM + b * matmul_pkg::BLOCK_SIZE + i]);
                end
                send_block(blk);
            end
        end
    endtask

    // Takes all C elements in row-major order with random ack delays
    task automatic collect_results(input int job);
        int               delay;
        matmul_pkg::sum_t exp;
        matmul_pkg::sum_t held;
        for (int idx = 0; idx < C_LEN; idx++) begin
            @(posedge clk);
            while (out_req !== 1'b1) @(posedge clk);
            exp  = matmul_pkg::sum_t'(c_tab[job][idx]);
            held = out_data;
            if (out_data !== exp) begin
                errors++;
                $display("FAILED out_data exp %h got %h (job %0d element %0d)",
                         exp, out_data, job, idx);
            end
            // Back-pressure, request and data must hold
            next_delay(delay);
            repeat (delay) begin
                @(posedge clk);
                if (out_req !== 1'b1) begin
                    errors++;
                    $display("out_req dropped before out_ack (job %0d element %0d)", job, idx);
                end
                if (out_data !== held) begin
                    errors++;
                    $display("FAILED out_data exp %h got %h while out_req high", held, out_data);
                end
            end
            #1 out_ack = 1'b1;
            @(posedge clk);
            while (out_req !== 1'b0) @(posedge clk);
            next_delay(delay);
            repeat (delay) @(posedge clk);
            #1 out_ack = 1'b0;
        end
    endtask

    // Load handshake monitor, values read at the edge are the ones the DUT saw
    always @(posedge clk) begin
        if (rst_n === 1'b1 && in_ack === 1'b1 && ack_q === 1'b0) begin
            ack_rises++;
            if (req_q !== 1'b1) begin
                errors++;
                $display("in_ack rose while in_req was low");
            end
        end
        ack_q <= in_ack;
        req_q <= in_req;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, DUT stopped responding", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int ack_base;
        rst_n   = 1'b0;
        in_req  = 1'b0;
        in_data = '0;
        out_ack = 1'b0;
        // Outputs quiet through reset and right after
        repeat (4) begin
            @(posedge clk);
            #1 check_quiet_outputs();
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1 check_quiet_outputs();

        for (int j = 0; j < NUM_JOBS; j++) begin
            ack_base = ack_rises;
            load_job(j);
            if (busy !== 1'b1) begin
                errors++;
                $display("FAILED busy exp 1 got %h (job %0d)", busy, j);
            end
            collect_results(j);
            // Nothing left over once the last result is acknowledged
            @(posedge clk);
            #1;
            if (out_req !== 1'b0) begin
                errors++;
                $display("Extra result offered after job %0d", j);
            end
            if (busy !== 1'b0) begin
                errors++;
                $display("FAILED busy exp 0 got %h (job %0d)", busy, j);
            end
            if (ack_rises - ack_base != LOADS) begin
                errors++;
                $display("Job %0d saw %0d in_ack rises for %0d load words",
                         j, ack_rises - ack_base, LOADS);
            end
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* source/matmul_top.sv */
/*
  Block matmul engine C = A x B, sizes fixed in matmul_pkg
  Load B column-major then A row-major, C leaves row-major
  busy drops once the last element reaches the result hold register
*/
`timescale 1ns/1ps

module matmul_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_req,
    input  matmul_pkg::block_t  in_data,
    output logic                in_ack,
    output logic                out_req,
    output matmul_pkg::sum_t    out_data,
    input  logic                out_ack,
    output logic                busy
);

    // Controller to buffers
    logic                                 w_wr_en;
    logic                                 n_wr_en;
    logic [matmul_pkg::W_ADDR_W-1:0]      wr_addr;
    matmul_pkg::block_t                   wr_data;
    logic                                 rd_en;
    logic [matmul_pkg::W_ADDR_W-1:0]      w_rd_addr;
    logic [matmul_pkg::N_ADDR_W-1:0]      n_rd_addr;
    logic                                 rd_first;
    logic                                 rd_last;

    // Buffers to dot stage
    matmul_pkg::block_t                   w_block;
    matmul_pkg::block_t                   n_block;

    // Dot stage to accumulator
    logic                                 part_valid;
    logic                                 part_first;
    logic                                 part_last;
    matmul_pkg::sum_t                     part_sum;
    logic                                 acc_done;

    buffer_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .in_data   (in_data),
        .in_ack    (in_ack),
        .w_wr_en   (w_wr_en),
        .n_wr_en   (n_wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .w_rd_addr (w_rd_addr),
        .n_rd_addr (n_rd_addr),
        .rd_first  (rd_first),
        .rd_last   (rd_last),
        .acc_done  (acc_done),
        .busy      (busy)
    );

    operand_buffer #(.DEPTH(matmul_pkg::W_DEPTH)) west_buf (
        .clk     (clk),
        .wr_en   (w_wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (w_rd_addr),
        .rd_data (w_block)
    );

    // North buffer is shallower, low address bits only
    operand_buffer #(.DEPTH(matmul_pkg::N_DEPTH)) north_buf (
        .clk     (clk),
        .wr_en   (n_wr_en),
        .wr_addr (wr_addr[matmul_pkg::N_ADDR_W-1:0]),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (n_rd_addr),
        .rd_data (n_block)
    );

    dot_block u_dot (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_valid   (rd_en),
        .rd_first   (rd_first),
        .rd_last    (rd_last),
        .w_block    (w_block),
        .n_block    (n_block),
        .part_valid (part_valid),
        .part_first (part_first),
        .part_last  (part_last),
        .part_sum   (part_sum)
    );

    result_acc u_acc (
        .clk        (clk),
        .rst_n      (rst_n),
        .part_valid (part_valid),
        .part_first (part_first),
        .part_last  (part_last),
        .part_sum   (part_sum),
        .acc_done   (acc_done),
        .out_req    (out_req),
        .out_data   (out_data),
        .out_ack    (out_ack)
    );

endmodule

/* source/result_acc.sv */
/*
  Sums partials per C element, one-deep hold register for the result port
  A finished sum waits in the accumulator while the hold register is full
  Result port is four-phase, out_req rises again only after out_ack is low
*/
`timescale 1ns/1ps

module result_acc (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              part_valid,
    input  logic              part_first,
    input  logic              part_last,
    input  matmul_pkg::sum_t  part_sum,
    output logic              acc_done,
    output logic              out_req,
    output matmul_pkg::sum_t  out_data,
    input  logic              out_ack
);

    matmul_pkg::sum_t acc_sum;
    matmul_pkg::sum_t acc_next;
    // Completed sum parked in acc_sum
    logic             pending;
    logic             hold_full;
    // Ack seen, waiting for it to drop
    logic             wait_low;
    logic             load_hold;

    // First partial restarts the sum
    assign acc_next = part_first ? part_sum : acc_sum + part_sum;

    // Move a finished sum when the hold register is free
    assign load_hold = ((part_valid && part_last) || pending) && !hold_full;

    assign out_req = hold_full && !wait_low;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            hold_full <= 1'b0;
            wait_low  <= 1'b0;
            acc_done  <= 1'b0;
        end else begin
            acc_done <= load_hold;

            if (load_hold) begin
                pending <= 1'b0;
            end else if (part_valid && part_last) begin
                pending <= 1'b1;
            end

            // Fill and drain never overlap, out_req needs a full register
            if (load_hold) begin
                hold_full <= 1'b1;
            end else if (out_req && out_ack) begin
                hold_full <= 1'b0;
            end

            if (out_req && out_ack) begin
                wait_low <= 1'b1;
            end else if (!out_ack) begin
                wait_low <= 1'b0;
            end
        end
    end

    // Sum and hold payload
    always_ff @(posedge clk) begin
        if (part_valid) begin
            acc_sum <= acc_next;
        end
        if (load_hold) begin
            out_data <= pending ? acc_sum : acc_next;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_req && !out_ack) |=> (out_req && $stable(out_data)))
        else $error("out_data or out_req changed before out_ack");

    // Controller must hold issue until acc_done frees the accumulator
    a_no_part_pending: assert property (@(posedge clk) disable iff (!rst_n)
        pending |-> !part_valid)
        else $error("partial arrived while a completed sum waits");

endmodule

/* source/dot_block.sv */
/*
  Two-stage path: tags wait one cycle for the buffer read data,
  then the BLOCK_SIZE products are summed and registered with them
*/
`timescale 1ns/1ps

module dot_block (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd_valid,
    input  logic                rd_first,
    input  logic                rd_last,
    input  matmul_pkg::block_t  w_block,
    input  matmul_pkg::block_t  n_block,
    output logic                part_valid,
    output logic                part_first,
    output logic                part_last,
    output matmul_pkg::sum_t    part_sum
);

    // Tags aligned with the buffer output
    logic             valid_d;
    logic             first_d;
    logic             last_d;
    matmul_pkg::sum_t dot_sum;

    // Sign-extend each pair, multiply and add
    always_comb begin
        dot_sum = '0;
        for (int i = 0; i < matmul_pkg::BLOCK_SIZE; i++) begin
            dot_sum = dot_sum + matmul_pkg::sum_t'($signed(w_block[i]))
                              * matmul_pkg::sum_t'($signed(n_block[i]));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_d    <= 1'b0;
            first_d    <= 1'b0;
            last_d     <= 1'b0;
            part_valid <= 1'b0;
            part_first <= 1'b0;
            part_last  <= 1'b0;
        end else begin
            valid_d    <= rd_valid;
            first_d    <= rd_first;
            last_d     <= rd_last;
            part_valid <= valid_d;
            part_first <= first_d;
            part_last  <= last_d;
        end
    end

    // Partial sum only moves with valid data
    always_ff @(posedge clk) begin
        if (valid_d) begin
            part_sum <= dot_sum;
        end
    end

endmodule

/* source/buffer_ctrl.sv */
/*
  Job FSM: N_DEPTH north words, then W_DEPTH west words, then compute
  Load port is four-phase req/ack, in_ack rises one cycle after in_req
  Buffers are not refilled while a job computes
*/
`timescale 1ns/1ps

module buffer_ctrl (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // Four-phase load port
    input  logic                                  in_req,
    input  matmul_pkg::block_t                    in_data,
    output logic                                  in_ack,
    // Buffer write side
    output logic                                  w_wr_en,
    output logic                                  n_wr_en,
    output logic [matmul_pkg::W_ADDR_W-1:0]       wr_addr,
    output matmul_pkg::block_t                    wr_data,
    // Buffer read side and tags
    output logic                                  rd_en,
    output logic [matmul_pkg::W_ADDR_W-1:0]       w_rd_addr,
    output logic [matmul_pkg::N_ADDR_W-1:0]       n_rd_addr,
    output logic                                  rd_first,
    output logic                                  rd_last,
    // From the accumulator
    input  logic                                  acc_done,
    output logic                                  busy
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_N,
        S_LOAD_W,
        S_COMPUTE,
        S_DONE
    } state_t;

    state_t state;

    // Load word counter, one bit wider to reach W_DEPTH
    logic [matmul_pkg::W_ADDR_W:0] ld_cnt;
    logic                          ld_room;
    logic                          accept;

    // Position in C and block within the dot product
    logic [matmul_pkg::ROW_W-1:0]  row;
    logic [matmul_pkg::COL_W-1:0]  col;
    logic [matmul_pkg::BLK_W-1:0]  blk;
    logic                          row_last;
    logic                          col_last;
    logic                          blk_last;

    // Element issued, result not yet taken by the accumulator
    logic                          wait_acc;

    // Space left in the current operand
    assign ld_room = (state == S_IDLE) ||
                     ((state == S_LOAD_N) && (ld_cnt != matmul_pkg::N_DEPTH)) ||
                     ((state == S_LOAD_W) && (ld_cnt != matmul_pkg::W_DEPTH));

    // New word only on the rising half of the handshake
    assign accept = in_req && !in_ack && ld_room;

    assign row_last = (row == matmul_pkg::ROW_W'(matmul_pkg::ROWS_M - 1));
    assign col_last = (col == matmul_pkg::COL_W'(matmul_pkg::COLS_N - 1));
    assign blk_last = (blk == matmul_pkg::BLK_W'(matmul_pkg::BLOCKS_PER_VEC - 1));

    // One read per cycle while an element is being issued
    assign rd_en    = (state == S_COMPUTE) && !wait_acc;
    assign rd_first = (blk == '0);
    assign rd_last  = blk_last;

    // Row-major A, column-major B, both indexed by block
    assign w_rd_addr = matmul_pkg::W_ADDR_W'(row * matmul_pkg::BLOCKS_PER_VEC + blk);
    assign n_rd_addr = matmul_pkg::N_ADDR_W'(col * matmul_pkg::BLOCKS_PER_VEC + blk);

    assign busy = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            in_ack   <= 1'b0;
            n_wr_en  <= 1'b0;
            w_wr_en  <= 1'b0;
            wr_addr  <= '0;
            ld_cnt   <= '0;
            row      <= '0;
            col      <= '0;
            blk      <= '0;
            wait_acc <= 1'b0;
        end else begin
            // Ack follows req, drops once req is seen low
            if (accept) begin
                in_ack <= 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;
            end

            // Write lands one cycle after accept, still inside the load state
            n_wr_en <= accept && (state != S_LOAD_W);
            w_wr_en <= accept && (state == S_LOAD_W);
            if (accept) begin
                wr_addr <= ld_cnt[matmul_pkg::W_ADDR_W-1:0];
                ld_cnt  <= ld_cnt + 1'b1;
            end

            case (state)
                S_IDLE: begin
                    // First north word starts the job
                    if (accept) begin
                        state <= S_LOAD_N;
                    end
                end

                S_LOAD_N: begin
                    // Leave on the cycle the last north word is written
                    if (ld_cnt == matmul_pkg::N_DEPTH) begin
                        state  <= S_LOAD_W;
                        ld_cnt <= '0;
                    end
                end

                S_LOAD_W: begin
                    if (ld_cnt == matmul_pkg::W_DEPTH) begin
                        state  <= S_COMPUTE;
                        ld_cnt <= '0;
                    end
                end

                S_COMPUTE: begin
                    if (rd_en) begin
                        if (blk_last) begin
                            // Element fully issued, step through C row-major
                            blk      <= '0;
                            wait_acc <= 1'b1;
                            if (col_last) begin
                                col <= '0;
                                if (row_last) begin
                                    row   <= '0;
                                    state <= S_DONE;
                                end else begin
                                    row <= row + 1'b1;
                                end
                            end else begin
                                col <= col + 1'b1;
                            end
                        end else begin
                            blk <= blk + 1'b1;
                        end
                    end else if (acc_done) begin
                        wait_acc <= 1'b0;
                    end
                end

                S_DONE: begin
                    // Final element taken into the hold register
                    if (acc_done) begin
                        wait_acc <= 1'b0;
                        state    <= S_IDLE;
                    end
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Payload register for the write port
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_data <= in_data;
        end
    end

    a_wr_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        (w_wr_en || n_wr_en) |-> ((state == S_LOAD_N) || (state == S_LOAD_W)))
        else $error("buffer write outside the load states");

    // After an element's last read, no new read until the accumulator takes it
    a_wait_acc: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_en && rd_last) |=> (!rd_en until_with acc_done))
        else $error("read issued while an element awaits acc_done");

endmodule

/* source/operand_buffer.sv */
/*
  Simple dual-port block memory, one write and one read port
  Read data is registered and appears the cycle after rd_en
  Contents are undefined until written, no reset on the array
*/
`timescale 1ns/1ps

module operand_buffer #(
    parameter int DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       wr_en,
    input  logic [$clog2(DEPTH)-1:0]   wr_addr,
    input  matmul_pkg::block_t         wr_data,
    input  logic                       rd_en,
    input  logic [$clog2(DEPTH)-1:0]   rd_addr,
    output matmul_pkg::block_t         rd_data
);

    // Block storage
    matmul_pkg::block_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read port, holds last word when idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // DEPTH need not be a power of two, so out-of-range codes exist
    a_addr_range: assert property (@(posedge clk)
        (wr_en |-> (wr_addr < DEPTH)) and (rd_en |-> (rd_addr < DEPTH)))
        else $error("operand_buffer address out of range");

endmodule

/* source/matmul_pkg.sv */
/*
  Fixed sizes and shared types for the block matmul engine
  INNER_DIM must be a whole multiple of BLOCK_SIZE, no run-time sizing
  ACC_W must hold INNER_DIM products of two ELEM_W values plus sign
*/
package matmul_pkg;

    // Element and block geometry
    localparam int ELEM_W     = 8;
    localparam int BLOCK_SIZE = 2;

    // Matrix shape: A is ROWS_M x INNER_DIM, B is INNER_DIM x COLS_N
    localparam int INNER_DIM  = 4;
    localparam int ROWS_M     = 3;
    localparam int COLS_N     = 2;

    // Blocks per row of A or per column of B
    localparam int BLOCKS_PER_VEC = INNER_DIM / BLOCK_SIZE;

    // Operand buffer depths in blocks
    localparam int W_DEPTH = ROWS_M * BLOCKS_PER_VEC;
    localparam int N_DEPTH = COLS_N * BLOCKS_PER_VEC;

    // Result width
    localparam int ACC_W = 20;

    // Address and counter widths
    localparam int W_ADDR_W = $clog2(W_DEPTH);
    localparam int N_ADDR_W = $clog2(N_DEPTH);
    localparam int ROW_W    = $clog2(ROWS_M);
    localparam int COL_W    = $clog2(COLS_N);
    localparam int BLK_W    = $clog2(BLOCKS_PER_VEC);

    typedef logic signed [ELEM_W-1:0] elem_t;

    // Element 0 sits in the low bits
    typedef elem_t [BLOCK_SIZE-1:0] block_t;

    typedef logic signed [ACC_W-1:0] sum_t;

endpackage
